/* src/stcBusPkg.sv */
package stcBusPkg;

    //**************************************************
    // Register bus types
    //**************************************************

    typedef logic [7:0]  regAddr_t;
    typedef logic [15:0] regData_t;

    // SPI frame opcodes, anything else is dropped
    typedef enum logic [7:0] {
        opWrite = 8'h01,
        opRead  = 8'h02
    } spiOpcode_t;

    //**************************************************
    // Register map
    //**************************************************

    localparam regAddr_t AddrVersion      = 8'h00;    // Read only
    localparam regAddr_t AddrClocksPerBit = 8'h01;
    localparam regAddr_t AddrBitPattern   = 8'h02;
    localparam regAddr_t AddrDacSelect    = 8'h03;
    localparam regAddr_t AddrTestLevel    = 8'h04;

    // Opcode, address and data, MSB first
    localparam int FrameBits = 32;

    // Write request from the SPI slave
    typedef struct packed {
        logic     write;
        regAddr_t addr;
        regData_t data;
    } busWrite_t;

endpackage

/* src/stcDataPkg.sv */
package stcDataPkg;

    //**************************************************
    // Sample formats
    //**************************************************

    localparam int AdcWidth    = 14;
    localparam int DacWidth    = 14;
    localparam int SampleWidth = 18;

    typedef logic [AdcWidth-1:0]           adcWord_t;    // Offset binary
    typedef logic [DacWidth-1:0]           dacWord_t;    // Offset binary
    typedef logic signed [SampleWidth-1:0] sample_t;

    // DAC source select, code 3 falls back to the ADC
    typedef enum logic [1:0] {
        dacSrcAdc       = 2'd0,
        dacSrcTestLevel = 2'd1,
        dacSrcBit       = 2'd2
    } dacSource_t;

    // Levels for the bit stream on the DAC, near full scale
    localparam sample_t BitHigh = 18'h1FFF0;
    localparam sample_t BitLow  = 18'h20010;

    //**************************************************
    // Configuration
    //**************************************************

    typedef struct packed {
        logic [15:0]        clocksPerBit;
        logic [15:0]        bitPattern;
        dacSource_t         dacSelect;
        logic signed [15:0] testLevel;
    } config_t;

endpackage

/* src/spiSlaveFsm.sv */
`timescale 1ns/100ps

module spiSlaveFsm (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 spiClk,
    input  logic                 spiCSn,
    input  logic                 spiDataIn,
    input  stcBusPkg::regData_t  rdData,
    output logic                 spiDataOut,
    output stcBusPkg::busWrite_t busWr,
    output stcBusPkg::regAddr_t  rdAddr
);

    import stcBusPkg::*;

    typedef enum logic [2:0] {
        idle,
        opcodePhase,
        addrPhase,
        dataPhase,
        finish
    } spiState_t;

    spiState_t                      state;
    spiOpcode_t                     opcode;
    logic [1:0]                     clkSync;
    logic [1:0]                     csSync;
    logic [1:0]                     dataSync;
    logic                           clkDly;
    logic                           clkRise;
    logic                           clkFall;
    logic                           csActive;
    logic                           sampleBit;
    logic                           lastOpcodeBit;
    logic                           lastAddrBit;
    logic                           lastDataBit;
    logic [$clog2(FrameBits)-1:0]   bitCnt;
    logic [FrameBits-1:0]           shiftIn;
    logic [FrameBits-1:0]           shiftOut;
    logic                           rdLoad;
    logic                           wrPulse;

    //**************************************************
    // Oversampling of the SPI pins
    //**************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            clkSync <= 2'b00;
            csSync  <= 2'b11;      // Deselected
            clkDly  <= 1'b0;
        end else begin
            clkSync <= {clkSync[0], spiClk};
            csSync  <= {csSync[0], spiCSn};
            clkDly  <= clkSync[1];
        end
    end

    always_ff @(posedge clk) begin
        dataSync <= {dataSync[0], spiDataIn};
    end

    assign clkRise  = clkSync[1] & ~clkDly;
    assign clkFall  = ~clkSync[1] & clkDly;
    assign csActive = ~csSync[1];

    assign sampleBit     = csActive && clkRise &&
                           (state inside {opcodePhase, addrPhase, dataPhase});
    assign lastOpcodeBit = sampleBit && (state == opcodePhase) && (bitCnt == 5'd7);
    assign lastAddrBit   = sampleBit && (state == addrPhase) && (bitCnt == 5'd15);
    assign lastDataBit   = sampleBit && (state == dataPhase) && (bitCnt == 5'd31);

    //**************************************************
    // Frame state machine
    //**************************************************

    always_ff @(posedge clk) begin
        if (rst || !csActive) begin
            state   <= idle;         // CS high aborts the frame
            bitCnt  <= '0;
            wrPulse <= 1'b0;
            rdLoad  <= 1'b0;
        end else begin
            wrPulse <= lastDataBit && (opcode == opWrite);
            rdLoad  <= lastAddrBit;
            if (sampleBit) begin
                bitCnt <= bitCnt + 1'b1;
            end
            case (state)
                idle:        state <= opcodePhase;
                opcodePhase: if (lastOpcodeBit) state <= addrPhase;
                addrPhase:   if (lastAddrBit) state <= dataPhase;
                dataPhase:   if (lastDataBit) state <= finish;
                default:     state <= finish;    // Wait for CS to go high
            endcase
        end
    end

    // Incoming bits, opcode and read address
    always_ff @(posedge clk) begin
        if (sampleBit) begin
            shiftIn <= {shiftIn[FrameBits-2:0], dataSync[1]};
        end
        if (lastOpcodeBit) begin
            opcode <= spiOpcode_t'({shiftIn[6:0], dataSync[1]});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdAddr <= '0;
        end else if (lastAddrBit) begin
            rdAddr <= {shiftIn[6:0], dataSync[1]};
        end
    end

    // Read data goes out on falling edges, MSB first
    always_ff @(posedge clk) begin
        if (rst || !csActive) begin
            shiftOut   <= '0;
            spiDataOut <= 1'b0;
        end else if (rdLoad) begin
            shiftOut <= (opcode == opRead) ? {rdData, 16'h0000} : '0;
        end else if (clkFall && state != idle) begin
            spiDataOut <= shiftOut[FrameBits-1];
            shiftOut   <= {shiftOut[FrameBits-2:0], 1'b0};
        end
    end

    assign busWr = '{write: wrPulse, addr: shiftIn[23:16], data: shiftIn[15:0]};

    // A write only follows a completed data phase of a selected frame
    writeInFrame: assert property (@(posedge clk) disable iff (rst)
        busWr.write |-> csActive && $past(state) == dataPhase);

endmodule

/* src/configRegs.sv */
`timescale 1ns/100ps

module configRegs #(
    parameter logic [15:0] VerNumber           = 16'd530,
    parameter logic [15:0] DefaultClocksPerBit = 16'd8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  stcBusPkg::busWrite_t busWr,
    input  stcBusPkg::regAddr_t  rdAddr,
    output stcBusPkg::regData_t  rdData,
    output stcDataPkg::config_t  cfg,
    output logic                 patternLoad
);

    import stcBusPkg::*;
    import stcDataPkg::*;

    //**************************************************
    // Write decode
    //**************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '{
                clocksPerBit: DefaultClocksPerBit,
                bitPattern:   16'h0000,
                dacSelect:    dacSrcAdc,
                testLevel:    16'sh0000
            };
            patternLoad <= 1'b0;
        end else begin
            patternLoad <= 1'b0;
            if (busWr.write) begin
                case (busWr.addr)
                    AddrClocksPerBit: cfg.clocksPerBit <= busWr.data;
                    AddrBitPattern: begin
                        cfg.bitPattern <= busWr.data;
                        patternLoad    <= 1'b1;     // Restart the bit stream
                    end
                    AddrDacSelect:    cfg.dacSelect <= dacSource_t'(busWr.data[1:0]);
                    AddrTestLevel:    cfg.testLevel <= signed'(busWr.data);
                    default: ;                     // Version and unmapped
                endcase
            end
        end
    end

    //**************************************************
    // Read mux
    //**************************************************

    always_comb begin
        case (rdAddr)
            AddrVersion:      rdData = VerNumber;
            AddrClocksPerBit: rdData = cfg.clocksPerBit;
            AddrBitPattern:   rdData = cfg.bitPattern;
            AddrDacSelect:    rdData = {14'h0000, cfg.dacSelect};
            AddrTestLevel:    rdData = unsigned'(cfg.testLevel);
            default:          rdData = '0;
        endcase
    end

endmodule

/* src/bitTimer.sv */
`timescale 1ns/100ps

module bitTimer (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] clocksPerBit,
    input  logic        restart,
    output logic        bitStrobe,
    output logic        clkPhase
);

    logic [15:0] period;
    logic [15:0] terminal;
    logic [15:0] count;

    // Shortest legal bit is two clocks
    assign period   = (clocksPerBit < 16'd2) ? 16'd2 : clocksPerBit;
    assign terminal = period - 16'd1;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            count <= '0;
        end else if (count >= terminal) begin
            count <= '0;           // Also catches a shortened period
        end else begin
            count <= count + 16'd1;
        end
    end

    assign bitStrobe = (count == terminal);
    assign clkPhase  = (count >= (period >> 1));   // High in second half

    countBounded: assert property (@(posedge clk) disable iff (rst)
        count < 16'hFFFF);

    countMoves: assert property (@(posedge clk) disable iff (rst)
        !restart |=> count != $past(count));

endmodule

/* src/bitPatternOutput.sv */
`timescale 1ns/100ps

module bitPatternOutput (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] bitPattern,
    input  logic        bitStrobe,
    input  logic        clkPhase,
    input  logic        restart,
    output logic        ch0ClkOut,
    output logic        ch0DataOut,
    output logic        bitValue
);

    logic [3:0] bitIndex;

    // Pattern goes out LSB first
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            bitIndex <= '0;
        end else if (bitStrobe) begin
            bitIndex <= bitIndex + 4'd1;
        end
    end

    //**************************************************
    // Registered clock and data
    //**************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            ch0DataOut <= 1'b0;
            ch0ClkOut  <= 1'b0;
        end else begin
            ch0ClkOut <= clkPhase;     // Rises mid bit
            if (bitStrobe && !restart) begin
                ch0DataOut <= bitPattern[bitIndex];
            end
        end
    end

    // Same bit feeds the DAC source mux
    assign bitValue = ch0DataOut;

endmodule

/* src/dacPath.sv */
`timescale 1ns/100ps

module dacPath (
    input  logic                   clk,
    input  logic                   rst,
    input  stcDataPkg::adcWord_t   adc0,
    input  stcDataPkg::dacSource_t dacSelect,
    input  logic signed [15:0]     testLevel,
    input  logic                   bitValue,
    output stcDataPkg::dacWord_t   dac0Data
);

    import stcDataPkg::*;

    adcWord_t adcReg;
    sample_t  adcSample;
    sample_t  dacSample;

    //**************************************************
    // ADC reclock and conversion to signed
    //**************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            adcReg    <= {1'b1, {(AdcWidth-1){1'b0}}};      // Offset-binary zero
            adcSample <= '0;
        end else begin
            adcReg    <= adc0;
            adcSample <= {~adcReg[AdcWidth-1], adcReg[AdcWidth-2:0],
                          {(SampleWidth-AdcWidth){1'b0}}};
        end
    end

    //**************************************************
    // Source mux and DAC format
    //**************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            dacSample <= '0;
        end else begin
            case (dacSelect)
                dacSrcTestLevel: dacSample <= {testLevel, {(SampleWidth-16){1'b0}}};
                dacSrcBit:       dacSample <= bitValue ? BitHigh : BitLow;
                default:         dacSample <= adcSample;    // ADC and the spare code
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dac0Data <= {1'b1, {(DacWidth-1){1'b0}}};
        end else begin
            // Back to offset binary from the top bits
            dac0Data <= {~dacSample[SampleWidth-1],
                         dacSample[SampleWidth-2 -: DacWidth-1]};
        end
    end

endmodule

/* src/stcDemodTop.sv */
`timescale 1ns/100ps

module stcDemodTop #(
    parameter logic [15:0] VerNumber           = 16'd530,
    parameter logic [15:0] DefaultClocksPerBit = 16'd8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 spiClk,
    input  logic                 spiCSn,
    input  logic                 spiDataIn,
    input  stcDataPkg::adcWord_t adc0,
    output logic                 spiDataOut,
    output stcDataPkg::dacWord_t dac0Data,
    output logic                 ch0ClkOut,
    output logic                 ch0DataOut
);

    import stcBusPkg::*;
    import stcDataPkg::*;

    busWrite_t busWr;
    regAddr_t  rdAddr;
    regData_t  rdData;
    config_t   cfg;
    logic      patternLoad;
    logic      bitStrobe;
    logic      clkPhase;
    logic      bitValue;

    //**************************************************
    // SPI configuration port
    //**************************************************

    spiSlaveFsm spiSlaveFsm_i (
        .clk        (clk),
        .rst        (rst),
        .spiClk     (spiClk),
        .spiCSn     (spiCSn),
        .spiDataIn  (spiDataIn),
        .rdData     (rdData),
        .spiDataOut (spiDataOut),
        .busWr      (busWr),
        .rdAddr     (rdAddr)
    );

    configRegs #(
        .VerNumber           (VerNumber),
        .DefaultClocksPerBit (DefaultClocksPerBit)
    ) configRegs_i (
        .clk         (clk),
        .rst         (rst),
        .busWr       (busWr),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .cfg         (cfg),
        .patternLoad (patternLoad)
    );

    //**************************************************
    // Clock and data output, channel 0
    //**************************************************

    bitTimer bitTimer_i (
        .clk          (clk),
        .rst          (rst),
        .clocksPerBit (cfg.clocksPerBit),
        .restart      (patternLoad),
        .bitStrobe    (bitStrobe),
        .clkPhase     (clkPhase)
    );

    bitPatternOutput bitPatternOutput_i (
        .clk        (clk),
        .rst        (rst),
        .bitPattern (cfg.bitPattern),
        .bitStrobe  (bitStrobe),
        .clkPhase   (clkPhase),
        .restart    (patternLoad),
        .ch0ClkOut  (ch0ClkOut),
        .ch0DataOut (ch0DataOut),
        .bitValue   (bitValue)
    );

    //**************************************************
    // ADC to DAC 0
    //**************************************************

    dacPath dacPath_i (
        .clk       (clk),
        .rst       (rst),
        .adc0      (adc0),
        .dacSelect (cfg.dacSelect),
        .testLevel (cfg.testLevel),
        .bitValue  (bitValue),
        .dac0Data  (dac0Data)
    );

endmodule

/* tb/stcDemodTb.sv */
`timescale 1ns/100ps

module stcDemodTb;

    import stcBusPkg::*;
    import stcDataPkg::*;

    localparam logic [15:0] VerNumber           = 16'd530;
    localparam logic [15:0] DefaultClocksPerBit = 16'd8;
    localparam int          ClkPeriod           = 40;
    localparam int          DriveDelay          = 5;
    localparam int          SpiHalfCycles       = 4;     // spiClk toggles every 4 clocks
    localparam int          EdgeTimeout         = 64;

    localparam int ModeNone = 0;
    localparam int ModeAdc  = 1;
    localparam int ModeBit  = 2;

    logic     clk;
    logic     rst;
    logic     spiClk;
    logic     spiCSn;
    logic     spiDataIn;
    adcWord_t adc0;
    logic     spiDataOut;
    dacWord_t dac0Data;
    logic     ch0ClkOut;
    logic     ch0DataOut;

    integer   seed       = 32'h2de2;
    int       cycleCount = 0;
    int       checkMode  = ModeNone;
    int       fillCount  = 0;
    adcWord_t adcHist [0:4];     // adc0 seen on the last five cycles
    logic     bitHist [0:2];

    stcDemodTop #(
        .VerNumber           (VerNumber),
        .DefaultClocksPerBit (DefaultClocksPerBit)
    ) stcDemodTop_i (
        .clk        (clk),
        .rst        (rst),
        .spiClk     (spiClk),
        .spiCSn     (spiCSn),
        .spiDataIn  (spiDataIn),
        .adc0       (adc0),
        .spiDataOut (spiDataOut),
        .dac0Data   (dac0Data),
        .ch0ClkOut  (ch0ClkOut),
        .ch0DataOut (ch0DataOut)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    //**************************************************
    // Reporting and compare tasks
    //**************************************************

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkReg(input string name, input regData_t got, input regData_t exp);
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkDac(input string name, input dacWord_t got, input dacWord_t exp);
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // Expected DAC code, worked out as a signed sample first
    function automatic dacWord_t refDac(input dacSource_t src, input adcWord_t adc,
                                        input logic signed [15:0] level, input logic bitVal);
        int sample;
        case (src)
            dacSrcTestLevel: sample = int'(level) * 4;
            dacSrcBit:       sample = bitVal ? int'(BitHigh) : int'(BitLow);
            default:         sample = (int'(adc) - 8192) * 16;    // Offset binary to signed
        endcase
        return dacWord_t'((sample >>> 4) + 8192);    // Top 14 bits, back to offset binary
    endfunction

    function automatic logic isRotation(input logic [15:0] seq, input logic [15:0] pattern);
        logic match;
        for (int r = 0; r < 16; r++) begin
            match = 1'b1;
            for (int i = 0; i < 16; i++) begin
                if (seq[i] != pattern[(r + i) % 16]) begin
                    match = 1'b0;
                end
            end
            if (match) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Sampled mid cycle, away from the drive edge
    always @(negedge clk) begin
        for (int i = 4; i > 0; i--) begin
            adcHist[i] = adcHist[i-1];
        end
        adcHist[0] = adc0;
        bitHist[2] = bitHist[1];
        bitHist[1] = bitHist[0];
        bitHist[0] = ch0DataOut;
        if (checkMode == ModeNone) begin
            fillCount = 0;
        end else if (fillCount < 8) begin
            fillCount = fillCount + 1;
        end
        if (checkMode == ModeAdc && fillCount > 5) begin
            checkDac("dac0Data", dac0Data, refDac(dacSrcAdc, adcHist[4], 16'sh0000, 1'b0));
        end
        if (checkMode == ModeBit && fillCount > 3) begin
            if (dac0Data != 14'h3FFF && dac0Data != 14'h0001) begin
                failRun($sformatf("[FAIL] %0t dac0Data got %h expected 3fff or 0001",
                                  $time, dac0Data));
            end
            checkDac("dac0Data", dac0Data, refDac(dacSrcBit, '0, 16'sh0000, bitHist[2]));
        end
    end

    //**************************************************
    // Stimulus helpers
    //**************************************************

    task automatic nextCycle();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic waitCycles(input int count);
        for (int i = 0; i < count; i++) begin
            nextCycle();
        end
    endtask

    // One SPI frame, MSB first, cut short after bitsToSend bits
    task automatic spiFrame(input logic [31:0] frame, input int bitsToSend,
                            output regData_t readBits);
        int waited;
        readBits = '0;
        waited   = 0;
        spiCSn   = 1'b0;
        waitCycles(SpiHalfCycles);
        for (int i = 0; i < bitsToSend; i++) begin
            spiDataIn = frame[31-i];
            waitCycles(SpiHalfCycles);
            if (i >= 16) begin
                readBits = {readBits[14:0], spiDataOut};   // Data phase
            end
            spiClk = 1'b1;
            waitCycles(SpiHalfCycles);
            spiClk = 1'b0;
        end
        waitCycles(SpiHalfCycles);
        spiCSn    = 1'b1;
        spiDataIn = 1'b0;
        while (spiDataOut !== 1'b0) begin
            if (waited == 8) begin
                failRun("spiDataOut stayed high after spiCSn went high");
            end
            nextCycle();
            waited++;
        end
        waitCycles(SpiHalfCycles);
    endtask

    task automatic spiWrite(input regAddr_t addr, input regData_t data);
        regData_t ignored;
        spiFrame({opWrite, addr, data}, FrameBits, ignored);
    endtask

    task automatic spiRead(input regAddr_t addr, output regData_t data);
        regData_t filler;
        filler = regData_t'($random(seed));
        spiFrame({opRead, addr, filler}, FrameBits, data);
    endtask

    task automatic waitClkRise(output int edgeCycle, output logic dataBit);
        logic prev;
        int   waited;
        prev      = ch0ClkOut;
        waited    = 0;
        edgeCycle = -1;
        dataBit   = 1'b0;
        while (edgeCycle < 0) begin
            @(negedge clk);
            if (ch0ClkOut && !prev) begin
                edgeCycle = cycleCount;
                dataBit   = ch0DataOut;
            end
            prev = ch0ClkOut;
            waited++;
            if (edgeCycle < 0 && waited == EdgeTimeout) begin
                failRun("no rising edge on ch0ClkOut within the timeout");
            end
        end
    endtask

    //**************************************************
    // Test sequence
    //**************************************************

    initial begin
        regData_t    got;
        regData_t    cpbVal;
        regData_t    patVal;
        regData_t    selVal;
        regData_t    lvlVal;
        regAddr_t    unmapped;
        logic [7:0]  badOp;
        logic [15:0] seq;
        dacWord_t    expDac;
        int          cut;
        int          nBits;
        int          lastEdge;
        int          edgeCycle;
        int          waited;
        logic        dataBit;

        rst       = 1'b1;
        spiClk    = 1'b0;
        spiCSn    = 1'b1;
        spiDataIn = 1'b0;
        adc0      = 14'h2000;
        waitCycles(4);
        rst = 1'b0;
        checkBit("spiDataOut", spiDataOut, 1'b0);
        checkBit("ch0ClkOut", ch0ClkOut, 1'b0);
        checkBit("ch0DataOut", ch0DataOut, 1'b0);
        checkDac("dac0Data", dac0Data, 14'h2000);

        // Version, default and unmapped reads
        spiRead(AddrVersion, got);
        checkReg("version", got, VerNumber);
        spiRead(AddrClocksPerBit, got);
        checkReg("clocksPerBit", got, DefaultClocksPerBit);
        unmapped = regAddr_t'(5 + ($unsigned($random(seed)) % 251));
        spiRead(unmapped, got);
        checkReg("unmapped register", got, 16'h0000);

        // Write and read back every writable register
        cpbVal = regData_t'($random(seed));
        patVal = regData_t'($random(seed));
        selVal = regData_t'($random(seed));
        lvlVal = regData_t'($random(seed));
        spiWrite(AddrClocksPerBit, cpbVal);
        spiWrite(AddrBitPattern, patVal);
        spiWrite(AddrDacSelect, selVal);
        spiWrite(AddrTestLevel, lvlVal);
        spiRead(AddrClocksPerBit, got);
        checkReg("clocksPerBit", got, cpbVal);
        spiRead(AddrBitPattern, got);
        checkReg("bitPattern", got, patVal);
        spiRead(AddrDacSelect, got);
        checkReg("dacSelect", got, selVal & 16'h0003);
        spiRead(AddrTestLevel, got);
        checkReg("testLevel", got, lvlVal);

        badOp = 8'($random(seed));
        if (badOp == opWrite || badOp == opRead) begin
            badOp = 8'hA5;
        end
        spiFrame({badOp, AddrTestLevel, ~lvlVal}, FrameBits, got);
        spiRead(AddrTestLevel, got);
        checkReg("testLevel after invalid opcode", got, lvlVal);
        cut = 9 + ($unsigned($random(seed)) % 23);     // Abort somewhere after the opcode
        spiFrame({opWrite, AddrBitPattern, ~patVal}, cut, got);
        spiRead(AddrBitPattern, got);
        checkReg("bitPattern after aborted frame", got, patVal);

        // ADC straight through to the DAC
        spiWrite(AddrDacSelect, regData_t'(dacSrcAdc));
        checkMode = ModeAdc;
        for (int i = 0; i < 200; i++) begin
            nextCycle();
            adc0 = adcWord_t'($random(seed));
        end
        checkMode = ModeNone;

        // Test level on the DAC
        lvlVal = regData_t'($random(seed));
        spiWrite(AddrTestLevel, lvlVal);
        spiWrite(AddrDacSelect, regData_t'(dacSrcTestLevel));
        expDac = refDac(dacSrcTestLevel, '0, signed'(lvlVal), 1'b0);
        waited = 0;
        while (dac0Data !== expDac && waited < 8) begin
            nextCycle();
            waited++;
        end
        checkDac("dac0Data", dac0Data, expDac);

        // Clock and data output
        nBits  = 2 + ($unsigned($random(seed)) % 11);
        patVal = regData_t'($random(seed));
        spiWrite(AddrClocksPerBit, regData_t'(nBits));
        spiWrite(AddrBitPattern, patVal);
        waitClkRise(lastEdge, dataBit);
        for (int i = 0; i < 16; i++) begin
            waitClkRise(edgeCycle, dataBit);
            checkReg("ch0ClkOut period", regData_t'(edgeCycle - lastEdge), regData_t'(nBits));
            seq[i]   = dataBit;
            lastEdge = edgeCycle;
        end
        nextCycle();
        if (!isRotation(seq, patVal)) begin
            failRun($sformatf("ch0DataOut bits %h are not a rotation of pattern %h",
                              seq, patVal));
        end

        // Bit stream on the DAC
        spiWrite(AddrDacSelect, regData_t'(dacSrcBit));
        checkMode = ModeBit;
        waitCycles(300);
        checkMode = ModeNone;

        $display("No errors");
        $finish;
    end

endmodule

/* src.f */
src/stcBusPkg.sv
src/stcDataPkg.sv
src/spiSlaveFsm.sv
src/configRegs.sv
src/bitTimer.sv
src/bitPatternOutput.sv
src/dacPath.sv
src/stcDemodTop.sv
tb/stcDemodTb.sv

/* Makefile */
# Verilator simulation of the STC demodulator testbench

VERILATOR ?= verilator
TOP       ?= stcDemodTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless the pass message is printed"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
